/* mini_pipe.f */
src/mini_pipe_pkg.sv
src/mini_pipe_if.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/mini_pipe.sv
testbench/mini_pipe_assertions.sv
testbench/tb_mini_pipe.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_mini_pipe -f mini_pipe.f \
  && ./obj_dir/Vtb_mini_pipe +verilator+error+limit+1000 | tee sim.log \
  || echo "build or simulation step failed"

grep -q "Simulation completed successfully" sim.log 2>/dev/null && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }

/* testbench/tb_mini_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mini_pipe;
  import mini_pipe_pkg::*;

  localparam int data_width     = 32;
  localparam int num_regs       = 32;
  localparam int mem_depth      = 16;
  localparam int clk_period     = 4;
  localparam int reset_cycles   = 4;
  localparam int directed_slots = 60;
  localparam int random_slots   = 400;
  localparam int watchdog_ns    =
    (reset_cycles + directed_slots + random_slots + 20) * clk_period;

  logic                      clk;
  logic                      rst_n;
  logic                      instr_valid;
  logic [inst_width-1:0]     instr;
  logic                      wb_valid;
  logic [reg_addr_width-1:0] wb_dst;
  logic [data_width-1:0]     wb_data;

  // sequential reference state
  logic [data_width-1:0]     ref_regs [num_regs];
  logic [data_width-1:0]     ref_mem [mem_depth];
  logic [reg_addr_width-1:0] exp_dst_q [$];
  logic [data_width-1:0]     exp_data_q [$];
  string                     exp_name_q [$];
  string                     test_name;
  logic [31:0]               rng_state;
  int                        value_errors;

  mini_pipe #(
    .data_width(data_width),
    .num_regs  (num_regs),
    .mem_depth (mem_depth)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_valid(instr_valid),
    .instr      (instr),
    .wb_valid   (wb_valid),
    .wb_dst     (wb_dst),
    .wb_data    (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random numbers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int rand_below(input int limit);
    return int'(rand_next() % limit);
  endfunction

  // r1..r7 keeps dependencies dense
  function automatic logic [reg_addr_width-1:0] pick_reg();
    return reg_addr_width'(1 + rand_below(7));
  endfunction

  function automatic logic [5:0] pick_op(input int sel);
    case (sel)
      0:       return op_add;
      1:       return op_sub;
      2:       return op_and;
      3:       return op_or;
      4:       return op_xor;
      5:       return op_slt;
      6:       return op_addi;
      7:       return op_ori;
      13:      return 6'h3f;
      default: return op_nop;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // issue with reference model
  ////////////////////////////////////////////////////////////

  task automatic issue(input logic [5:0] op, input logic [reg_addr_width-1:0] rs,
                       input logic [reg_addr_width-1:0] rt,
                       input logic [reg_addr_width-1:0] rd, input logic [15:0] imm);
    logic [data_width-1:0]     a;
    logic [data_width-1:0]     b;
    logic [data_width-1:0]     zimm;
    logic [data_width-1:0]     result;
    logic [reg_addr_width-1:0] dst;
    logic                      writes;
    logic                      rtype;
    int unsigned               idx;
    a      = ref_regs[rs];
    b      = ref_regs[rt];
    zimm   = {16'h0000, imm};
    idx    = (a + zimm) % mem_depth;
    result = '0;
    writes = 1'b1;
    case (op)
      op_add:  result = a + b;
      op_sub:  result = a - b;
      op_and:  result = a & b;
      op_or:   result = a | b;
      op_xor:  result = a ^ b;
      op_slt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_addi: result = a + zimm;
      op_ori:  result = a | zimm;
      op_lw:   result = ref_mem[idx];
      op_sw: begin
        ref_mem[idx] = b;
        writes       = 1'b0;
      end
      default: writes = 1'b0;
    endcase
    rtype = !(op == op_addi || op == op_ori || op == op_lw || op == op_sw);
    dst   = rtype ? rd : rt;
    if (writes && dst != '0) begin
      ref_regs[dst] = result;
      exp_dst_q.push_back(dst);
      exp_data_q.push_back(result);
      exp_name_q.push_back(test_name);
    end
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= rtype ? {op, rs, rt, rd, 11'h000} : {op, rs, rt, imm};
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      instr_valid <= 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed programs
  ////////////////////////////////////////////////////////////

  task automatic run_alu_ops();
    test_name = "alu_ops";
    issue(op_addi, 5'd0, 5'd1, 5'd0, 16'h8001);
    issue(op_ori, 5'd0, 5'd2, 5'd0, 16'hf0f0);
    idle(3);
    // r3 goes negative, so slt sees a signed compare
    issue(op_sub, 5'd0, 5'd1, 5'd3, 16'h0);
    issue(op_slt, 5'd3, 5'd1, 5'd4, 16'h0);
    issue(op_slt, 5'd1, 5'd3, 5'd5, 16'h0);
    issue(op_and, 5'd1, 5'd2, 5'd6, 16'h0);
    issue(op_xor, 5'd1, 5'd2, 5'd7, 16'h0);
    issue(op_or, 5'd6, 5'd7, 5'd1, 16'h0);
    issue(op_add, 5'd1, 5'd2, 5'd2, 16'h0);
    idle(4);
  endtask

  // distance 1, 2 and 3 between producer and consumer
  task automatic run_dependency();
    test_name = "dependency";
    issue(op_addi, 5'd0, 5'd1, 5'd0, 16'd7);
    issue(op_add, 5'd1, 5'd1, 5'd2, 16'h0);
    issue(op_sub, 5'd2, 5'd1, 5'd3, 16'h0);
    issue(op_xor, 5'd1, 5'd3, 5'd4, 16'h0);
    idle(1);
    issue(op_or, 5'd3, 5'd4, 5'd5, 16'h0);
    idle(2);
    issue(op_addi, 5'd5, 5'd6, 5'd0, 16'h0100);
    issue(op_slt, 5'd6, 5'd5, 5'd7, 16'h0);
    idle(4);
  endtask

  task automatic run_store_load();
    test_name = "store_load";
    issue(op_addi, 5'd0, 5'd1, 5'd0, 16'h1234);
    issue(op_addi, 5'd0, 5'd2, 5'd0, 16'd5);
    issue(op_sw, 5'd2, 5'd1, 5'd0, 16'd3);
    issue(op_lw, 5'd2, 5'd3, 5'd0, 16'd3);
    // load followed at once by a use
    issue(op_add, 5'd3, 5'd3, 5'd4, 16'h0);
    issue(op_lw, 5'd0, 5'd5, 5'd0, 16'd9);
    issue(op_sw, 5'd0, 5'd4, 5'd0, 16'd9);
    idle(1);
    issue(op_lw, 5'd0, 5'd6, 5'd0, 16'd9);
    issue(op_sub, 5'd6, 5'd3, 5'd7, 16'h0);
    idle(4);
  endtask

  task automatic run_no_writeback();
    test_name = "no_writeback";
    issue(op_nop, 5'd1, 5'd2, 5'd3, 16'h0);
    issue(6'h3f, 5'd1, 5'd2, 5'd3, 16'h0);
    issue(op_addi, 5'd1, 5'd0, 5'd0, 16'h0055);
    issue(op_add, 5'd1, 5'd1, 5'd0, 16'h0);
    issue(op_sw, 5'd0, 5'd1, 5'd0, 16'd2);
    issue(op_add, 5'd0, 5'd0, 5'd1, 16'h0);
    idle(4);
  endtask

  task automatic run_random(input int slots);
    int                        sel;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] rd;
    logic [15:0]               imm;
    test_name = "random";
    for (int n = 0; n < slots; n++) begin
      sel = rand_below(16);
      rs  = pick_reg();
      rt  = pick_reg();
      rd  = pick_reg();
      imm = 16'(rand_next());
      if (rand_below(16) == 0) begin
        rd = '0;
        rt = '0;
      end
      if (sel >= 14) begin
        idle(1);
      end else if (sel >= 8 && sel <= 11) begin
        issue((sel < 10) ? op_lw : op_sw, rs, rt, rd, 16'(rand_below(mem_depth)));
      end else begin
        issue(pick_op(sel), rs, rt, rd, imm);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // writeback checks
  ////////////////////////////////////////////////////////////

  task automatic check_writeback();
    logic [reg_addr_width-1:0] exp_dst;
    logic [data_width-1:0]     exp_data;
    string                     name;
    if (exp_dst_q.size() == 0) begin
      value_errors++;
      $display("writeback to r%0d arrived with no instruction outstanding", wb_dst);
    end else begin
      exp_dst  = exp_dst_q.pop_front();
      exp_data = exp_data_q.pop_front();
      name     = exp_name_q.pop_front();
      assert (wb_dst == exp_dst)
        else begin
          value_errors++;
          $display("ERR %s: wb_dst expected %0d actual %0d", name, exp_dst, wb_dst);
        end
      assert (wb_data == exp_data)
        else begin
          value_errors++;
          $display("ERR %s: wb_data expected 0x%08h actual 0x%08h", name, exp_data, wb_data);
        end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && wb_valid) begin
      check_writeback();
    end
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: writebacks still outstanding after %0d ns", watchdog_ns);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    rng_state    = 32'd57097;
    value_errors = 0;
    test_name    = "reset";
    for (int i = 0; i < num_regs; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < mem_depth; i++) begin
      ref_mem[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    run_no_writeback();
    run_alu_ops();
    run_dependency();
    run_store_load();
    run_random(random_slots);
    idle(1);
    while (exp_dst_q.size() != 0) begin
      @(posedge clk);
    end
    // trailing stores and bound checks finish within the pipe depth
    repeat (4) @(posedge clk);
    $display("errors: %0d value mismatches, %0d assertion failures",
             value_errors, i_dut.u_assertions.fail_count);
    if (value_errors == 0 && i_dut.u_assertions.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/mini_pipe_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mini_pipe_assertions #(
  parameter int data_width = 32
) (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic                                     instr_valid,
  input logic [mini_pipe_pkg::inst_width-1:0]     instr,
  input logic                                     wb_valid,
  input logic [mini_pipe_pkg::reg_addr_width-1:0] wb_dst,
  input logic [data_width-1:0]                    wb_data
);
  import mini_pipe_pkg::*;

  logic [5:0]                opcode;
  logic [reg_addr_width-1:0] issue_dst;
  logic                      issue_writes;
  logic                      seen_write;
  int unsigned               fail_count = 0;

  assign opcode = instr[opcode_msb -: 6];

  // which sampled instructions must come back as a writeback
  always_comb begin
    issue_dst    = instr[rt_lsb +: reg_addr_width];
    issue_writes = 1'b0;
    case (opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
        issue_dst    = instr[rd_lsb +: reg_addr_width];
        issue_writes = instr_valid;
      end
      op_addi, op_ori, op_lw: issue_writes = instr_valid;
      default: ;
    endcase
    if (issue_dst == '0) begin
      issue_writes = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seen_write <= 1'b0;
    end else if (issue_writes) begin
      seen_write <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // reset state and writeback timing
  ////////////////////////////////////////////////////////////

  reset_clear: assert property (@(posedge clk) !rst_n |=> !wb_valid)
    else begin
      fail_count++;
      $error("wb_valid high in the cycle after reset");
    end

  quiet_start: assert property (@(posedge clk) disable iff (!rst_n) !seen_write |-> !wb_valid)
    else begin
      fail_count++;
      $error("writeback before any writing instruction was issued");
    end

  wb_follows_issue: assert property (@(posedge clk) disable iff (!rst_n)
      $past(issue_writes, 3) |-> wb_valid)
    else begin
      fail_count++;
      $error("no writeback three edges after a writing instruction");
    end

  // also catches nop, sw and r0 writes that leak out
  wb_has_issue: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid |-> $past(issue_writes, 3) && (wb_dst == $past(issue_dst, 3)))
    else begin
      fail_count++;
      $error("writeback without a matching writing instruction three edges back");
    end

  wb_known: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid |-> !$isunknown(wb_data))
    else begin
      fail_count++;
      $error("wb_data unknown while wb_valid is high");
    end

endmodule

bind mini_pipe mini_pipe_assertions #(
  .data_width(data_width)
) u_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .instr_valid(instr_valid),
  .instr      (instr),
  .wb_valid   (wb_valid),
  .wb_dst     (wb_dst),
  .wb_data    (wb_data)
);

`default_nettype wire

/* src/mini_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module mini_pipe #(
  parameter int data_width = 32,
  parameter int num_regs   = 32,
  parameter int mem_depth  = 16
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     instr_valid,
  input  logic [mini_pipe_pkg::inst_width-1:0]     instr,
  output logic                                     wb_valid,
  output logic [mini_pipe_pkg::reg_addr_width-1:0] wb_dst,
  output logic [data_width-1:0]                    wb_data
);

  ////////////////////////////////////////////////////////////
  // stage buses
  ////////////////////////////////////////////////////////////

  exec_if #(
    .data_width(data_width)
  ) ex_bus ();

  result_if #(
    .data_width(data_width)
  ) res_bus ();

  ////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////

  decode_stage #(
    .data_width(data_width),
    .num_regs  (num_regs)
  ) u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_valid(instr_valid),
    .instr      (instr),
    .ex         (ex_bus),
    .wb         (res_bus)
  );

  execute_stage #(
    .data_width(data_width)
  ) u_execute (
    .clk  (clk),
    .rst_n(rst_n),
    .ex   (ex_bus),
    .res  (res_bus)
  );

  // drives the writeback outputs directly from its register
  result_stage #(
    .data_width(data_width),
    .mem_depth (mem_depth)
  ) u_result (
    .clk     (clk),
    .rst_n   (rst_n),
    .res     (res_bus),
    .wb_valid(wb_valid),
    .wb_dst  (wb_dst),
    .wb_data (wb_data)
  );

endmodule

`default_nettype wire

/* src/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
  parameter int data_width = 32,
  parameter int mem_depth  = 16
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  result_if.result                                 res,
  output logic                                     wb_valid,
  output logic [mini_pipe_pkg::reg_addr_width-1:0] wb_dst,
  output logic [data_width-1:0]                    wb_data
);
  import mini_pipe_pkg::*;

  localparam int addr_width = $clog2(mem_depth);

  logic [data_width-1:0]     mem [mem_depth];
  logic [addr_width-1:0]     addr;
  logic [data_width-1:0]     read_data;
  logic                      wb_valid_q;
  logic [reg_addr_width-1:0] wb_dst_q;
  logic [data_width-1:0]     wb_data_q;

  ////////////////////////////////////////////////////////////
  // word addressed data memory
  ////////////////////////////////////////////////////////////

  assign addr      = res.alu_result[addr_width-1:0];
  assign read_data = mem[addr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < mem_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (res.valid && res.mem_op == mem_write) begin
      mem[addr] <= res.store_data;
    end
  end

  // ex-stage forward value and writeback value
  assign res.fwd_data = (res.mem_op == mem_read) ? read_data : res.alu_result;

  // result register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= res.valid && res.reg_write && (res.dst != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (res.valid) begin
      wb_dst_q  <= res.dst;
      wb_data_q <= res.fwd_data;
    end
  end

  assign res.wb_valid = wb_valid_q;
  assign res.wb_dst   = wb_dst_q;
  assign res.wb_data  = wb_data_q;
  assign wb_valid     = wb_valid_q;
  assign wb_dst       = wb_dst_q;
  assign wb_data      = wb_data_q;

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
  parameter int data_width = 32
) (
  input  logic      clk,
  input  logic      rst_n,
  exec_if.execute   ex,
  result_if.execute res
);
  import mini_pipe_pkg::*;

  logic                      ex_hit_a;
  logic                      ex_hit_b;
  logic                      wb_hit_a;
  logic                      wb_hit_b;
  logic [data_width-1:0]     op_a;
  logic [data_width-1:0]     fwd_b;
  logic [data_width-1:0]     op_b;
  logic [data_width-1:0]     alu_result;
  logic [reg_addr_width-1:0] dst;

  ////////////////////////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////////////////////////

  // entry in the execute register is younger, so it wins
  assign ex_hit_a = res.valid && res.reg_write && (res.dst != '0) && (res.dst == ex.rs);
  assign ex_hit_b = res.valid && res.reg_write && (res.dst != '0) && (res.dst == ex.rt);

  // wb_valid already implies a write to a nonzero register
  assign wb_hit_a = res.wb_valid && (res.wb_dst == ex.rs);
  assign wb_hit_b = res.wb_valid && (res.wb_dst == ex.rt);

  assign op_a  = ex_hit_a ? res.fwd_data :
                 wb_hit_a ? res.wb_data  : ex.operand_a;
  assign fwd_b = ex_hit_b ? res.fwd_data :
                 wb_hit_b ? res.wb_data  : ex.operand_b;

  // immediate is zero extended
  assign op_b = ex.alu_src ? {{(data_width-imm_width){1'b0}}, ex.imm} : fwd_b;

  ////////////////////////////////////////////////////////////
  // alu and destination select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ex.alu_op)
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_xor: alu_result = op_a ^ op_b;
      alu_slt: alu_result = {{(data_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = op_a + op_b;
    endcase
  end

  assign dst = ex.reg_dst ? ex.dst_rd : ex.dst_rt;

  // execute pipeline register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex.valid) begin
      res.alu_result <= alu_result;
      // forwarded rt is the sw store data
      res.store_data <= fwd_b;
      res.dst        <= dst;
      res.reg_write  <= ex.reg_write;
      res.mem_op     <= ex.mem_op;
    end
  end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
  parameter int data_width = 32,
  parameter int num_regs   = 32
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 instr_valid,
  input  logic [mini_pipe_pkg::inst_width-1:0] instr,
  exec_if.decode                               ex,
  result_if.writeback                          wb
);
  import mini_pipe_pkg::*;

  opcode_t                   opcode;
  logic [reg_addr_width-1:0] rs;
  logic [reg_addr_width-1:0] rt;
  logic [reg_addr_width-1:0] rd;
  logic [imm_width-1:0]      imm;
  alu_op_t                   alu_op;
  mem_op_t                   mem_op;
  logic                      alu_src;
  logic                      reg_dst;
  logic                      reg_write;
  logic [data_width-1:0]     regs [num_regs];
  logic [data_width-1:0]     rs_data;
  logic [data_width-1:0]     rt_data;

  assign opcode = opcode_t'(instr[opcode_msb -: $bits(opcode_t)]);
  assign rs     = instr[rs_lsb +: reg_addr_width];
  assign rt     = instr[rt_lsb +: reg_addr_width];
  assign rd     = instr[rd_lsb +: reg_addr_width];
  assign imm    = instr[imm_width-1:0];

  ////////////////////////////////////////////////////////////
  // control unit
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_op    = alu_add;
    mem_op    = mem_none;
    alu_src   = 1'b0;
    reg_dst   = 1'b0;
    reg_write = 1'b0;
    case (opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
        reg_dst   = 1'b1;
        reg_write = 1'b1;
        case (opcode)
          op_sub:  alu_op = alu_sub;
          op_and:  alu_op = alu_and;
          op_or:   alu_op = alu_or;
          op_xor:  alu_op = alu_xor;
          op_slt:  alu_op = alu_slt;
          default: alu_op = alu_add;
        endcase
      end
      op_addi, op_ori, op_lw: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
        if (opcode == op_ori) begin
          alu_op = alu_or;
        end
        if (opcode == op_lw) begin
          mem_op = mem_read;
        end
      end
      op_sw: begin
        alu_src = 1'b1;
        mem_op  = mem_write;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // register file with writeback pass-through to reads
  ////////////////////////////////////////////////////////////

  function automatic logic [data_width-1:0] read_reg(input logic [reg_addr_width-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (wb.wb_valid && wb.wb_dst == addr) begin
      return wb.wb_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs_data = read_reg(rs);
    rt_data = read_reg(rt);
  end

  // r0 never gets a wb_valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wb_valid) begin
      regs[wb.wb_dst] <= wb.wb_data;
    end
  end

  // decode pipeline register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      ex.alu_op    <= alu_op;
      ex.rs        <= rs;
      ex.rt        <= rt;
      ex.dst_rd    <= rd;
      ex.dst_rt    <= rt;
      ex.reg_dst   <= reg_dst;
      ex.operand_a <= rs_data;
      ex.operand_b <= rt_data;
      ex.imm       <= imm;
      ex.alu_src   <= alu_src;
      ex.reg_write <= reg_write;
      ex.mem_op    <= mem_op;
    end
  end

endmodule

`default_nettype wire

/* src/mini_pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decode register to execute
interface exec_if #(
  parameter int data_width = 32
) ();
  import mini_pipe_pkg::*;

  logic                      valid;
  alu_op_t                   alu_op;
  logic [reg_addr_width-1:0] rs;
  logic [reg_addr_width-1:0] rt;
  logic [reg_addr_width-1:0] dst_rd;
  logic [reg_addr_width-1:0] dst_rt;
  logic                      reg_dst;
  logic [data_width-1:0]     operand_a;
  logic [data_width-1:0]     operand_b;
  logic [imm_width-1:0]      imm;
  logic                      alu_src;
  logic                      reg_write;
  mem_op_t                   mem_op;

  modport decode (output valid, alu_op, rs, rt, dst_rd, dst_rt, reg_dst, operand_a,
                  operand_b, imm, alu_src, reg_write, mem_op);
  modport execute (input valid, alu_op, rs, rt, dst_rd, dst_rt, reg_dst, operand_a,
                   operand_b, imm, alu_src, reg_write, mem_op);
endinterface

// execute register to result plus the forward and writeback paths back
interface result_if #(
  parameter int data_width = 32
) ();
  import mini_pipe_pkg::*;

  logic                      valid;
  logic [data_width-1:0]     alu_result;
  logic [data_width-1:0]     store_data;
  logic [reg_addr_width-1:0] dst;
  logic                      reg_write;
  mem_op_t                   mem_op;
  logic [data_width-1:0]     fwd_data;
  logic                      wb_valid;
  logic [reg_addr_width-1:0] wb_dst;
  logic [data_width-1:0]     wb_data;

  modport execute (output valid, alu_result, store_data, dst, reg_write, mem_op,
                   input fwd_data, wb_valid, wb_dst, wb_data);
  modport result (input valid, alu_result, store_data, dst, reg_write, mem_op,
                  output fwd_data, wb_valid, wb_dst, wb_data);
  modport writeback (input wb_valid, wb_dst, wb_data);
endinterface

`default_nettype wire

/* src/mini_pipe_pkg.sv */
`default_nettype none

package mini_pipe_pkg;

  ////////////////////////////////////////////////////////////
  // instruction format
  ////////////////////////////////////////////////////////////

  parameter int inst_width     = 32;
  parameter int reg_addr_width = 5;

  // opcode 31..26, rs 25..21, rt 20..16, rd 15..11, imm 15..0
  parameter int opcode_msb = 31;
  parameter int rs_lsb     = 21;
  parameter int rt_lsb     = 16;
  parameter int rd_lsb     = 11;
  parameter int imm_width  = 16;

  ////////////////////////////////////////////////////////////
  // operation encodings
  ////////////////////////////////////////////////////////////

  // anything not listed decodes as nop
  typedef enum logic [5:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_slt  = 6'h06,
    op_addi = 6'h08,
    op_ori  = 6'h0d,
    op_lw   = 6'h23,
    op_sw   = 6'h2b
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_slt = 3'd5
  } alu_op_t;

  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_read  = 2'd1,
    mem_write = 2'd2
  } mem_op_t;

endpackage

`default_nettype wire
